// File: branchResolve.sv
`timescale 1ns/1ns

module branchResolve (
	input pipePkg::exMemT memEntry,
	input logic stall,
	output logic branchTaken,
	output logic [pipePkg::xlen-1:0] branchTarget
);
	import pipePkg::*;

	logic condMet;

	always_comb begin
		case (memEntry.branchType)
			brEq: condMet = memEntry.cond.zero;
			brNe: condMet = !memEntry.cond.zero;
			brLt: condMet = memEntry.cond.negative;
			default: condMet = 1'b0;
		endcase
	end

	// Held branch reports only in its last cycle
	assign branchTaken = condMet && !stall;
	assign branchTarget = memEntry.addr;

endmodule

// File: dataMem.sv
`timescale 1ns/1ns

module dataMem #(
	parameter int memDepth = 256
) (
	input logic clk,
	input logic [$clog2(memDepth)-1:0] wordAddr,
	input logic [3:0] byteStrobe,
	input logic [pipePkg::xlen-1:0] writeData,
	input logic readEn,
	output logic [pipePkg::xlen-1:0] readData
);
	import pipePkg::*;

	localparam int lanes = xlen / 8;

	logic [xlen-1:0] mem [memDepth];

	// ==============================
	// Byte-strobed write, registered read
	// ==============================
	always_ff @(posedge clk) begin
		for (int lane = 0; lane < lanes; lane++) begin
			if (byteStrobe[lane]) begin
				mem[wordAddr][8*lane +: 8] <= writeData[8*lane +: 8];
			end
		end
		// Same-cycle write is not visible here, old word comes back
		if (readEn) begin
			readData <= mem[wordAddr];
		end
	end

endmodule

// File: exMemReg.sv
`timescale 1ns/1ns

module exMemReg (
	input logic clk,
	input logic rstN,
	input logic stall,
	input logic flush,
	input pipePkg::exMemT exIn,
	output pipePkg::exMemT memEntry
);
	import pipePkg::*;

	exMemT nextEntry;

	// ==============================
	// Next-state selection
	// ==============================
	always_comb begin
		if (flush) begin
			nextEntry = '0; // Bubble, flush beats stall
		end else if (stall) begin
			nextEntry = memEntry;
		end else begin
			nextEntry = exIn;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			memEntry <= '0;
		end else begin
			memEntry <= nextEntry;
		end
	end

endmodule

// File: loadStoreUnit.sv
`timescale 1ns/1ns

module loadStoreUnit #(
	parameter int memDepth = 256
) (
	input logic stall,
	input pipePkg::exMemT memEntry,
	input pipePkg::memWbT wbEntry,
	input logic [pipePkg::xlen-1:0] readData,
	output logic [$clog2(memDepth)-1:0] wordAddr,
	output logic [3:0] byteStrobe,
	output logic [pipePkg::xlen-1:0] writeData,
	output logic readEn,
	output logic [pipePkg::xlen-1:0] loadValue
);
	import pipePkg::*;

	localparam int addrW = $clog2(memDepth);

	logic [1:0] storeOff;
	logic [3:0] sizeStrobe;
	logic [xlen-1:0] shifted;

	// ==============================
	// Store side
	// ==============================
	assign storeOff = memEntry.addr[1:0];
	assign wordAddr = memEntry.addr[2 +: addrW];

	always_comb begin
		case (memEntry.memSize)
			sizeByte: begin
				sizeStrobe = 4'b0001 << storeOff;
				writeData = {4{memEntry.storeData[7:0]}};
			end
			sizeHalf: begin
				sizeStrobe = storeOff[1] ? 4'b1100 : 4'b0011;
				writeData = {2{memEntry.storeData[15:0]}};
			end
			sizeWord: begin
				sizeStrobe = 4'b1111;
				writeData = memEntry.storeData;
			end
			default: begin
				sizeStrobe = 4'b0000;
				writeData = memEntry.storeData;
			end
		endcase
	end

	// No strobes while held, so a stalled store lands once
	assign byteStrobe = (memEntry.memWe && !stall) ? sizeStrobe : 4'b0000;
	assign readEn = memEntry.memRe && !stall;

	// ==============================
	// Load side
	// ==============================
	assign shifted = readData >> {wbEntry.byteOff, 3'b000};

	always_comb begin
		case (wbEntry.memSize)
			sizeByte: begin
				loadValue = {{(xlen-8){wbEntry.signExt & shifted[7]}}, shifted[7:0]};
			end
			sizeHalf: begin
				loadValue = {{(xlen-16){wbEntry.signExt & shifted[15]}}, shifted[15:0]};
			end
			default: begin
				loadValue = shifted; // Full word, nothing to extend
			end
		endcase
	end

endmodule

// File: memStageTb.sv
`timescale 1ns/1ns

module memStageTb;
	import pipePkg::*;

	localparam int cycleLimit = 600; // Tests need about 160 cycles

	logic clk = 1'b0;
	logic rstN;
	logic stall;
	logic flush;
	exMemT exIn;
	logic branchTaken;
	logic [xlen-1:0] branchTarget;
	logic wbWe;
	logic [regIdxW-1:0] wbRd;
	logic [xlen-1:0] wbData;

	integer seed = 32'h9f090965;
	int errors = 0;
	int cycles = 0;
	int watchHits = 0;
	logic [regIdxW-1:0] watchRd = '0;

	// Reference model state
	logic [7:0] refMem [1024];
	exMemT mEntry;
	memWbT mWb;
	logic [xlen-1:0] mRead;
	exMemT curIn;
	logic curStall;
	logic curFlush;
	logic curRstN;

	memStageTop #(.memDepth(256)) DUT (
		.clk(clk),
		.rstN(rstN),
		.stall(stall),
		.flush(flush),
		.exIn(exIn),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.wbWe(wbWe),
		.wbRd(wbRd),
		.wbData(wbData)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("Timeout after %0d cycles, errors %0d", cycles, errors);
			$display("test failed");
			$finish;
		end
	end

	// ==============================
	// Instruction builders
	// ==============================
	function automatic exMemT aluOp(logic [4:0] rd, logic [31:0] val);
		exMemT e = '0;
		e.rd = rd;
		e.regWe = 1'b1;
		e.result = val;
		e.wbSel = wbAlu;
		return e;
	endfunction

	function automatic exMemT upperOp(logic [4:0] rd, logic [19:0] imm);
		exMemT e = '0;
		e.rd = rd;
		e.regWe = 1'b1;
		e.imm20 = imm;
		e.wbSel = wbUpper;
		return e;
	endfunction

	function automatic exMemT storeOp(logic [31:0] addr, logic [31:0] data, memSizeT size);
		exMemT e = '0;
		e.addr = addr;
		e.storeData = data;
		e.memSize = size;
		e.memWe = 1'b1;
		return e;
	endfunction

	function automatic exMemT loadOp(logic [4:0] rd, logic [31:0] addr, memSizeT size,
			logic sext);
		exMemT e = '0;
		e.rd = rd;
		e.regWe = 1'b1;
		e.addr = addr;
		e.memSize = size;
		e.memRe = 1'b1;
		e.signExt = sext;
		e.wbSel = wbMem;
		return e;
	endfunction

	function automatic exMemT branchOp(branchTypeT bt, logic [1:0] flags, logic [31:0] target);
		exMemT e = '0;
		e.branchType = bt;
		e.cond = flags;
		e.addr = target;
		return e;
	endfunction

	// Random aligned byte address inside the first 16 words
	function automatic logic [31:0] pickAddr(memSizeT size);
		logic [31:0] word;
		logic [31:0] off;
		word = $random(seed) & 32'hf;
		off = $random(seed) & 32'h3;
		if (size == sizeHalf) off = off & 32'h2;
		if (size == sizeWord) off = 0;
		return (word << 2) | off;
	endfunction

	// ==============================
	// Reference model
	// ==============================
	task automatic updateModel();
		int base;
		int half;
		if (!curRstN) begin
			mEntry = '0;
			mWb = '0;
		end else begin
			base = int'(mEntry.addr[9:2]) * 4;
			if (mEntry.memRe && !curStall) begin // Read before write returns old data
				for (int i = 0; i < 4; i++) mRead[8*i +: 8] = refMem[base + i];
			end
			if (mEntry.memWe && !curStall) begin
				case (mEntry.memSize)
					sizeByte: refMem[base + int'(mEntry.addr[1:0])] = mEntry.storeData[7:0];
					sizeHalf: begin
						half = base + (mEntry.addr[1] ? 2 : 0);
						refMem[half] = mEntry.storeData[7:0];
						refMem[half + 1] = mEntry.storeData[15:8];
					end
					default: begin
						for (int i = 0; i < 4; i++) refMem[base + i] = mEntry.storeData[8*i +: 8];
					end
				endcase
			end
			if (curStall) begin
				mWb = '0;
			end else begin
				mWb.result = mEntry.result;
				mWb.rd = mEntry.rd;
				mWb.regWe = mEntry.regWe;
				mWb.wbSel = mEntry.wbSel;
				mWb.memSize = mEntry.memSize;
				mWb.signExt = mEntry.signExt;
				mWb.byteOff = mEntry.addr[1:0];
				mWb.imm20 = mEntry.imm20;
			end
			if (curFlush) mEntry = '0;
			else if (!curStall) mEntry = curIn;
		end
	endtask

	function automatic logic [31:0] expectedData();
		logic [15:0] h;
		logic [7:0] b;
		case (mWb.wbSel)
			wbUpper: return {mWb.imm20, 12'h000};
			wbMem: begin
				b = mRead[8*mWb.byteOff +: 8];
				h = mRead[8*mWb.byteOff +: 16];
				if (mWb.memSize == sizeByte) return mWb.signExt ? {{24{b[7]}}, b} : {24'h0, b};
				if (mWb.memSize == sizeHalf) return mWb.signExt ? {{16{h[15]}}, h} : {16'h0, h};
				return mRead;
			end
			default: return mWb.result;
		endcase
	endfunction

	function automatic logic expectedTaken();
		if (curStall) return 1'b0;
		case (mEntry.branchType)
			brEq: return mEntry.cond.zero;
			brNe: return !mEntry.cond.zero;
			brLt: return mEntry.cond.negative;
			default: return 1'b0;
		endcase
	endfunction

	task automatic checkOutputs();
		logic [31:0] expData;
		logic expBr;
		if (!curRstN) return;
		expBr = expectedTaken();
		assert (wbWe === mWb.regWe) else begin
			errors++;
			$display("FAILED wbWe expected %h got %h", mWb.regWe, wbWe);
		end
		if (mWb.regWe) begin
			expData = expectedData();
			assert (wbRd === mWb.rd) else begin
				errors++;
				$display("FAILED wbRd expected %h got %h", mWb.rd, wbRd);
			end
			assert (wbData === expData) else begin
				errors++;
				$display("FAILED wbData expected %h got %h", expData, wbData);
			end
		end
		assert (branchTaken === expBr) else begin
			errors++;
			$display("FAILED branchTaken expected %h got %h", expBr, branchTaken);
		end
		if (expBr) begin
			assert (branchTarget === mEntry.addr) else begin
				errors++;
				$display("FAILED branchTarget expected %h got %h", mEntry.addr, branchTarget);
			end
		end
		if (wbWe === 1'b1 && wbRd === watchRd) watchHits++;
	endtask

	// One clock that models the edge, drives new inputs and checks at the falling edge
	task automatic step(exMemT inst, logic st = 1'b0, logic fl = 1'b0, logic rs = 1'b1);
		@(posedge clk);
		updateModel();
		curIn = inst;
		curStall = st;
		curFlush = fl;
		curRstN = rs;
		exIn <= inst;
		stall <= st;
		flush <= fl;
		rstN <= rs;
		@(negedge clk);
		checkOutputs();
	endtask

	task automatic drain();
		repeat (3) step('0);
	endtask

	// ==============================
	// Tests
	// ==============================
	task automatic resetIdle();
		repeat (7) step('0, 1'b0, 1'b0, 1'b0); // Initial low level covers the first of eight reset edges
		repeat (4) step('0);
	endtask

	task automatic aluUpperStream();
		for (int i = 0; i < 20; i++) begin
			if (i % 2) step(upperOp(5'(i + 1), 20'($random(seed))));
			else step(aluOp(5'(i + 1), $random(seed)));
		end
		drain();
	endtask

	task automatic storeLoadSizes();
		memSizeT size;
		for (int w = 0; w < 16; w++) step(storeOp(w * 4, $random(seed), sizeWord));
		for (int i = 0; i < 24; i++) begin
			size = memSizeT'(($random(seed) & 32'h7fffffff) % 3);
			step(storeOp(pickAddr(size), $random(seed), size));
		end
		for (int i = 0; i < 30; i++) begin
			size = memSizeT'(($random(seed) & 32'h7fffffff) % 3);
			step(loadOp(5'(1 + i % 31), pickAddr(size), size, 1'($random(seed))));
		end
		drain();
	endtask

	task automatic branchTable();
		exMemT inst;
		for (int t = 0; t < 4; t++) begin
			for (int f = 0; f < 4; f++) begin
				step(branchOp(branchTypeT'(t), 2'(f), $random(seed)));
			end
		end
		drain();
		// Held taken branch reports once, when the stall drops
		inst = branchOp(brEq, 2'b10, $random(seed));
		step(inst);
		repeat (3) step(inst, 1'b1);
		step('0);
		drain();
	endtask

	task automatic stallHold();
		exMemT inst;
		inst = aluOp(5'd29, 32'hcafe0029);
		watchRd = 5'd29;
		watchHits = 0;
		step(inst);
		repeat (4) step(inst, 1'b1);
		step('0);
		drain();
		assert (watchHits == 1) else begin
			errors++;
			$display("Stalled instruction written back %0d times instead of once", watchHits);
		end
		// Stalled store followed by a load of the same word
		inst = storeOp(32'h20, 32'h5a5a1234, sizeWord);
		step(inst);
		repeat (3) step(inst, 1'b1);
		step(loadOp(5'd3, 32'h20, sizeWord, 1'b0));
		drain();
	endtask

	task automatic flushDrop();
		watchRd = 5'd30;
		watchHits = 0;
		step(storeOp(32'h30, 32'h11223344, sizeWord));
		step(storeOp(32'h30, 32'hdeadbeef, sizeWord), 1'b0, 1'b1);
		step(aluOp(5'd30, 32'h0badf00d), 1'b0, 1'b1);
		step('0);
		step(loadOp(5'd4, 32'h30, sizeWord, 1'b0));
		drain();
		assert (watchHits == 0) else begin
			errors++;
			$display("Flushed instruction reached writeback");
		end
	endtask

	initial begin
		rstN = 1'b0;
		stall = 1'b0;
		flush = 1'b0;
		exIn = '0;
		curIn = '0;
		curStall = 1'b0;
		curFlush = 1'b0;
		curRstN = 1'b0;
		mEntry = '0;
		mWb = '0;
		mRead = '0;
		resetIdle();
		aluUpperStream();
		storeLoadSizes();
		branchTable();
		stallHold();
		flushDrop();
		$display("Finished after %0d cycles, errors %0d", cycles, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// File: memStageTop.sv
`timescale 1ns/1ns

module memStageTop #(
	parameter int memDepth = 256
) (
	input logic clk,
	input logic rstN,
	input logic stall,
	input logic flush,
	input pipePkg::exMemT exIn,
	output logic branchTaken,
	output logic [pipePkg::xlen-1:0] branchTarget,
	output logic wbWe,
	output logic [pipePkg::regIdxW-1:0] wbRd,
	output logic [pipePkg::xlen-1:0] wbData
);
	import pipePkg::*;

	localparam int addrW = $clog2(memDepth);

	exMemT memEntry;
	memWbT wbEntry;
	logic [addrW-1:0] wordAddr;
	logic [3:0] byteStrobe;
	logic [xlen-1:0] writeData;
	logic readEn;
	logic [xlen-1:0] readData;
	logic [xlen-1:0] loadValue;

	// ==============================
	// Memory stage
	// ==============================
	exMemReg exMemRegInst (
		.clk(clk),
		.rstN(rstN),
		.stall(stall),
		.flush(flush),
		.exIn(exIn),
		.memEntry(memEntry)
	);

	branchResolve branchResolveInst (
		.memEntry(memEntry),
		.stall(stall),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget)
	);

	loadStoreUnit #(.memDepth(memDepth)) loadStoreUnitInst (
		.stall(stall),
		.memEntry(memEntry),
		.wbEntry(wbEntry),
		.readData(readData),
		.wordAddr(wordAddr),
		.byteStrobe(byteStrobe),
		.writeData(writeData),
		.readEn(readEn),
		.loadValue(loadValue)
	);

	dataMem #(.memDepth(memDepth)) dataMemInst (
		.clk(clk),
		.wordAddr(wordAddr),
		.byteStrobe(byteStrobe),
		.writeData(writeData),
		.readEn(readEn),
		.readData(readData)
	);

	// ==============================
	// Writeback stage
	// ==============================
	writebackStage writebackStageInst (
		.clk(clk),
		.rstN(rstN),
		.stall(stall),
		.memEntry(memEntry),
		.loadValue(loadValue),
		.wbEntry(wbEntry),
		.wbWe(wbWe),
		.wbRd(wbRd),
		.wbData(wbData)
	);

endmodule

// File: memStage_checker.sv
`timescale 1ns/1ns

module memStageChecker (
	input logic clk,
	input logic rstN,
	input logic stall,
	input logic branchTaken,
	input logic wbWe,
	input logic [3:0] byteStrobe
);

	// ==============================
	// Reset state
	// ==============================
	property quietAfterReset;
		@(posedge clk) !rstN |=> (!wbWe && !branchTaken);
	endproperty

	assert property (quietAfterReset)
		else $error("wbWe or branchTaken high in the cycle after a reset edge");

	// ==============================
	// Stall rules
	// ==============================
	property noBranchWhileStalled;
		@(posedge clk) disable iff (!rstN) stall |-> !branchTaken;
	endproperty

	property noStrobeWhileStalled;
		@(posedge clk) disable iff (!rstN) stall |-> (byteStrobe == 4'b0000);
	endproperty

	assert property (noBranchWhileStalled)
		else $error("branchTaken high while stall is high");

	assert property (noStrobeWhileStalled) // Held store must not rewrite
		else $error("byte strobes active while stall is high");

endmodule

bind memStageTop memStageChecker memStageCheck (
	.clk(clk),
	.rstN(rstN),
	.stall(stall),
	.branchTaken(branchTaken),
	.wbWe(wbWe),
	.byteStrobe(byteStrobe)
);

// File: pipePkg.sv
package pipePkg;

	// ==============================
	// Widths
	// ==============================
	localparam int xlen = 32;
	localparam int regIdxW = 5;

	// ==============================
	// Control encodings
	// ==============================
	typedef enum logic [1:0] {
		sizeByte = 2'd0,
		sizeHalf = 2'd1,
		sizeWord = 2'd2
	} memSizeT;

	typedef enum logic [1:0] {
		brNone = 2'd0, // Zero so a cleared entry is never a branch
		brEq = 2'd1,
		brNe = 2'd2,
		brLt = 2'd3
	} branchTypeT;

	typedef enum logic [1:0] {
		wbAlu = 2'd0,
		wbMem = 2'd1,
		wbUpper = 2'd2
	} wbSelT;

	typedef struct packed {
		logic zero;
		logic negative;
	} condT;

	// Instruction entering the memory stage
	typedef struct packed {
		logic [xlen-1:0] result;
		logic [xlen-1:0] storeData;
		logic [xlen-1:0] addr; // Effective address, also branch target
		condT cond;
		logic [regIdxW-1:0] rd;
		memSizeT memSize;
		logic memWe;
		logic memRe;
		logic regWe;
		branchTypeT branchType;
		wbSelT wbSel;
		logic signExt;
		logic [19:0] imm20;
	} exMemT;

	// Memory-to-writeback register contents
	typedef struct packed {
		logic [xlen-1:0] result;
		logic [regIdxW-1:0] rd;
		logic regWe;
		wbSelT wbSel;
		memSizeT memSize;
		logic signExt;
		logic [1:0] byteOff; // Lane of the load within the word
		logic [19:0] imm20;
	} memWbT;

endpackage

// File: run.sh
#!/bin/sh
# Build and run the memory stage testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module memStageTb -o memStageSim \
	> build.log 2>&1 \
	&& ./obj_dir/memStageSim > sim.log 2>&1 \
	; grep -q "^test passed$" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see build.log and sim.log"; exit 1; }

// File: verilog.f
pipePkg.sv
exMemReg.sv
branchResolve.sv
dataMem.sv
loadStoreUnit.sv
writebackStage.sv
memStageTop.sv
memStage_checker.sv
memStageTb.sv

// File: writebackStage.sv
`timescale 1ns/1ns

module writebackStage (
	input logic clk,
	input logic rstN,
	input logic stall,
	input pipePkg::exMemT memEntry,
	input logic [pipePkg::xlen-1:0] loadValue,
	output pipePkg::memWbT wbEntry,
	output logic wbWe,
	output logic [pipePkg::regIdxW-1:0] wbRd,
	output logic [pipePkg::xlen-1:0] wbData
);
	import pipePkg::*;

	memWbT captured;

	// Pick out what writeback still needs
	always_comb begin
		captured.result = memEntry.result;
		captured.rd = memEntry.rd;
		captured.regWe = memEntry.regWe;
		captured.wbSel = memEntry.wbSel;
		captured.memSize = memEntry.memSize;
		captured.signExt = memEntry.signExt;
		captured.byteOff = memEntry.addr[1:0];
		captured.imm20 = memEntry.imm20;
	end

	// ==============================
	// Stage register
	// ==============================
	always_ff @(posedge clk) begin
		if (!rstN || stall) begin
			wbEntry <= '0; // Bubble while the stage above is held
		end else begin
			wbEntry <= captured;
		end
	end

	// ==============================
	// Writeback select
	// ==============================
	always_comb begin
		case (wbEntry.wbSel)
			wbAlu: wbData = wbEntry.result;
			wbMem: wbData = loadValue;
			wbUpper: wbData = {wbEntry.imm20, 12'b0};
			default: wbData = wbEntry.result;
		endcase
	end

	assign wbWe = wbEntry.regWe;
	assign wbRd = wbEntry.rd;

endmodule
